// File: include/bio_settings.svh
// widths, synchronizer depth, register offsets
// and device numbers for the board I/O subsystem
`ifndef BIO_SETTINGS_SVH
`define BIO_SETTINGS_SVH

`define BIO_ADDR_W        6
`define BIO_DATA_W        32
`define BIO_OFF_W         4
`define BIO_SYNC_STAGES   2
`define BIO_TIMER_W       32

// board device
`define BIO_OFF_HEX0      4'd0
`define BIO_OFF_HEX1      4'd1
`define BIO_OFF_HEX2      4'd2
`define BIO_OFF_HEX3      4'd3
`define BIO_OFF_HEX4      4'd4
`define BIO_OFF_HEX5      4'd5
`define BIO_OFF_HEX6      4'd6
`define BIO_OFF_HEX7      4'd7
`define BIO_OFF_LED_R     4'd8
`define BIO_OFF_LED_G     4'd9
`define BIO_OFF_INPUT     4'd10
`define BIO_OFF_KEYPRESS  4'd11

// timer device
`define BIO_OFF_TDIV      4'd0
`define BIO_OFF_TSTAT     4'd1
`define BIO_OFF_TCOUNT    4'd2

`define BIO_DEV_BOARD     2'd0
`define BIO_DEV_TIMER     2'd1

`endif

// File: rtl/bio_pkg.sv
// bus, display, key and switch types
// and the device-select encoding
`default_nettype none

`include "bio_settings.svh"

package bio_pkg;

  typedef logic [`BIO_DATA_W-1:0] word_t;
  typedef logic [`BIO_ADDR_W-1:0] addr_t;
  typedef logic [`BIO_OFF_W-1:0]  off_t;

  // upper word address bits, values 2 and 3 unmapped
  typedef enum logic [`BIO_ADDR_W-`BIO_OFF_W-1:0] {
    DEV_BOARD = `BIO_DEV_BOARD,
    DEV_TIMER = `BIO_DEV_TIMER
  } dev_sel_t;

  // segments active high on the bus
  typedef logic [6:0]  seg_t;
  // keys active high after inversion
  typedef logic [2:0]  key_t;
  typedef logic [17:0] sw_t;
  typedef logic [17:0] led_r_t;
  typedef logic [8:0]  led_g_t;

endpackage

`default_nettype wire

// File: rtl/bio_bus_if.sv
// per-device strobe bus between the controller and one device
`timescale 1ns/100ps
`default_nettype none

interface bio_bus_if;
  import bio_pkg::*;

  logic  stb;
  logic  we;
  off_t  off;
  word_t wdata;
  word_t rdata;

  modport ctrl (
    output stb,
    output we,
    output off,
    output wdata,
    input  rdata
  );

  modport dev (
    input  stb,
    input  we,
    input  off,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: rtl/input_sync.sv
// multi-stage synchronizer for an arbitrary payload type
`timescale 1ns/100ps
`default_nettype none

`include "bio_settings.svh"

module input_sync #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  payload_t d,
  output payload_t q
);

  payload_t stage [`BIO_SYNC_STAGES];

  always_ff @(posedge clk) begin
    stage[0] <= d;
    for (int i = 1; i < `BIO_SYNC_STAGES; i++) begin
      stage[i] <= stage[i-1];
    end
  end

  assign q = stage[`BIO_SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: rtl/io_bus_ctrl.sv
// bus controller: device decode, strobe routing,
// read data mux and ack
`timescale 1ns/100ps
`default_nettype none

`include "bio_settings.svh"

module io_bus_ctrl (
  input  logic           clk,
  input  logic           rst,
  input  logic           stb,
  input  logic           we,
  input  bio_pkg::addr_t addr,
  input  bio_pkg::word_t wdata,
  output bio_pkg::word_t rdata,
  output logic           ack,
  bio_bus_if.ctrl        bus_board,
  bio_bus_if.ctrl        bus_timer
);
  import bio_pkg::*;

  dev_sel_t dev_sel;
  off_t     off;

  assign dev_sel = dev_sel_t'(addr[`BIO_ADDR_W-1:`BIO_OFF_W]);
  assign off     = addr[`BIO_OFF_W-1:0];

  // strobe only reaches the selected device
  assign bus_board.stb   = stb && (dev_sel == DEV_BOARD);
  assign bus_board.we    = we;
  assign bus_board.off   = off;
  assign bus_board.wdata = wdata;

  assign bus_timer.stb   = stb && (dev_sel == DEV_TIMER);
  assign bus_timer.we    = we;
  assign bus_timer.off   = off;
  assign bus_timer.wdata = wdata;

  // unmapped devices read as zero
  always_comb begin
    case (dev_sel)
      DEV_BOARD: rdata = bus_board.rdata;
      DEV_TIMER: rdata = bus_timer.rdata;
      default:   rdata = '0;
    endcase
  end

  // no wait states
  assign ack = stb;

endmodule

`default_nettype wire

// File: rtl/board_out_regs.sv
// LED and seven-segment output registers
`timescale 1ns/100ps
`default_nettype none

`include "bio_settings.svh"

module board_out_regs (
  input  logic             clk,
  input  logic             rst,
  bio_bus_if.dev           bus,
  output bio_pkg::led_g_t  led_g,
  output bio_pkg::led_r_t  led_r,
  output bio_pkg::seg_t    hex_n [0:7]
);
  import bio_pkg::*;

  logic  wr;
  seg_t  wr_seg;

  assign wr     = bus.stb && bus.we;
  // digits are active low on the board
  assign wr_seg = ~bus.wdata[$bits(seg_t)-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      led_g <= '0;
      led_r <= '0;
      // blank display
      for (int i = 0; i < 8; i++) begin
        hex_n[i] <= '1;
      end
    end else if (wr) begin
      case (bus.off)
        `BIO_OFF_HEX0:  hex_n[0] <= wr_seg;
        `BIO_OFF_HEX1:  hex_n[1] <= wr_seg;
        `BIO_OFF_HEX2:  hex_n[2] <= wr_seg;
        `BIO_OFF_HEX3:  hex_n[3] <= wr_seg;
        `BIO_OFF_HEX4:  hex_n[4] <= wr_seg;
        `BIO_OFF_HEX5:  hex_n[5] <= wr_seg;
        `BIO_OFF_HEX6:  hex_n[6] <= wr_seg;
        `BIO_OFF_HEX7:  hex_n[7] <= wr_seg;
        `BIO_OFF_LED_R: led_r <= bus.wdata[$bits(led_r_t)-1:0];
        `BIO_OFF_LED_G: led_g <= bus.wdata[$bits(led_g_t)-1:0];
        default: begin
          // input side and unmapped offsets, nothing to store here
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/board_in_regs.sv
// key and switch inputs, packed input word,
// sticky key-press latch and board read data
`timescale 1ns/100ps
`default_nettype none

`include "bio_settings.svh"

module board_in_regs (
  input  logic         clk,
  input  logic         rst,
  bio_bus_if.dev       bus,
  input  logic [2:0]   key_n,
  input  bio_pkg::sw_t sw
);
  import bio_pkg::*;

  localparam int PAD_W = `BIO_DATA_W - $bits(key_t) - $bits(sw_t);

  key_t  key_s;
  key_t  key_prev;
  key_t  key_rise;
  key_t  key_clr;
  key_t  keypress;
  sw_t   sw_s;
  word_t in_word;

  input_sync #(.payload_t(key_t)) u_key_sync (.clk(clk), .d(~key_n), .q(key_s));
  input_sync #(.payload_t(sw_t))  u_sw_sync  (.clk(clk), .d(sw),     .q(sw_s));

  assign in_word = {key_s, {PAD_W{1'b0}}, sw_s};

  // ######################################################################
  // key-press latch, write one to clear, set wins
  // ######################################################################
  assign key_rise = key_s & ~key_prev;
  assign key_clr  = (bus.stb && bus.we && bus.off == `BIO_OFF_KEYPRESS) ?
                    bus.wdata[$bits(key_t)-1:0] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      key_prev <= '0;
      keypress <= '0;
    end else begin
      key_prev <= key_s;
      keypress <= (keypress & ~key_clr) | key_rise;
    end
  end

  always_comb begin
    case (bus.off)
      `BIO_OFF_INPUT:    bus.rdata = in_word;
      `BIO_OFF_KEYPRESS: bus.rdata = word_t'(keypress);
      default:           bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/interval_timer.sv
// interval timer: reloading down-counter, expired status, irq
`timescale 1ns/100ps
`default_nettype none

`include "bio_settings.svh"

module interval_timer (
  input  logic   clk,
  input  logic   rst,
  bio_bus_if.dev bus,
  output logic   irq
);
  import bio_pkg::*;

  logic [`BIO_TIMER_W-1:0] divisor;
  logic [`BIO_TIMER_W-1:0] count;
  logic                    expired;
  logic                    wr;
  logic                    exp_set;
  logic                    exp_clr;

  assign wr      = bus.stb && bus.we;
  // counter only runs with a nonzero divisor
  assign exp_set = (divisor != '0) && (count == '0);
  assign exp_clr = wr && (bus.off == `BIO_OFF_TSTAT) && bus.wdata[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      divisor <= '0;
      count   <= '0;
      expired <= 1'b0;
    end else begin
      if (wr && bus.off == `BIO_OFF_TDIV) begin
        divisor <= bus.wdata[`BIO_TIMER_W-1:0];
        count   <= bus.wdata[`BIO_TIMER_W-1:0];
      end else if (exp_set) begin
        count <= divisor;
      end else if (divisor != '0) begin
        count <= count - 1'b1;
      end
      expired <= (expired && !exp_clr) || exp_set;
    end
  end

  always_comb begin
    case (bus.off)
      `BIO_OFF_TDIV:   bus.rdata = word_t'(divisor);
      `BIO_OFF_TSTAT:  bus.rdata = word_t'(expired);
      `BIO_OFF_TCOUNT: bus.rdata = word_t'(count);
      default:         bus.rdata = '0;
    endcase
  end

  assign irq = expired;

endmodule

`default_nettype wire

// File: rtl/bio_top.sv
// board I/O subsystem top: bus controller, display outputs,
// board inputs and interval timer
`timescale 1ns/100ps
`default_nettype none

module bio_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            stb,
  input  logic            we,
  input  bio_pkg::addr_t  addr,
  input  bio_pkg::word_t  wdata,
  output bio_pkg::word_t  rdata,
  output logic            ack,
  output bio_pkg::led_g_t led_g,
  output bio_pkg::led_r_t led_r,
  output bio_pkg::seg_t   hex0_n,
  output bio_pkg::seg_t   hex1_n,
  output bio_pkg::seg_t   hex2_n,
  output bio_pkg::seg_t   hex3_n,
  output bio_pkg::seg_t   hex4_n,
  output bio_pkg::seg_t   hex5_n,
  output bio_pkg::seg_t   hex6_n,
  output bio_pkg::seg_t   hex7_n,
  input  logic [2:0]      key_n,
  input  bio_pkg::sw_t    sw,
  output logic            irq
);
  import bio_pkg::*;

  seg_t hex_n [0:7];

  bio_bus_if bus_board ();
  bio_bus_if bus_timer ();

  io_bus_ctrl u_io_bus_ctrl (
    .clk       (clk),
    .rst       (rst),
    .stb       (stb),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .rdata     (rdata),
    .ack       (ack),
    .bus_board (bus_board.ctrl),
    .bus_timer (bus_timer.ctrl)
  );

  // both board blocks sit on the same device bus
  board_out_regs u_board_out_regs (
    .clk   (clk),
    .rst   (rst),
    .bus   (bus_board.dev),
    .led_g (led_g),
    .led_r (led_r),
    .hex_n (hex_n)
  );

  board_in_regs u_board_in_regs (
    .clk   (clk),
    .rst   (rst),
    .bus   (bus_board.dev),
    .key_n (key_n),
    .sw    (sw)
  );

  interval_timer u_interval_timer (
    .clk (clk),
    .rst (rst),
    .bus (bus_timer.dev),
    .irq (irq)
  );

  assign hex0_n = hex_n[0];
  assign hex1_n = hex_n[1];
  assign hex2_n = hex_n[2];
  assign hex3_n = hex_n[3];
  assign hex4_n = hex_n[4];
  assign hex5_n = hex_n[5];
  assign hex6_n = hex_n[6];
  assign hex7_n = hex_n[7];

endmodule

`default_nettype wire

// File: testbench/bio_sva.sv
// bound assertions on the strobe bus handshake
// and on the output reset values
`timescale 1ns/100ps
`default_nettype none

module bio_sva #(
  parameter bit BUS_CHECKS = 1'b1,
  parameter bit OUT_CHECKS = 1'b1
) (
  input logic                          clk,
  input logic                          rst,
  input logic                          stb,
  input logic                          ack,
  input logic [1:0]                    dev_stb,
  input bio_pkg::led_g_t               led_g,
  input bio_pkg::led_r_t               led_r,
  input logic [8*$bits(bio_pkg::seg_t)-1:0] hex_flat
);

  if (BUS_CHECKS) begin : g_bus
    // same-cycle handshake without wait states
    ack_follows_stb: assert property (@(posedge clk) ack == stb)
      else $error("ack differs from stb");

    one_dev_stb: assert property (@(posedge clk) $onehot0(dev_stb))
      else $error("more than one device strobe high");

    dev_stb_gated: assert property (@(posedge clk) (dev_stb != '0) |-> stb)
      else $error("device strobe high without the bus strobe");
  end

  if (OUT_CHECKS) begin : g_out
    // blank display and dark LEDs once reset has been applied
    reset_outputs: assert property (@(posedge clk)
        rst |=> (hex_flat == '1 && led_g == '0 && led_r == '0))
      else $error("outputs not at reset values after reset");
  end

endmodule

bind io_bus_ctrl bio_sva #(.BUS_CHECKS(1'b1), .OUT_CHECKS(1'b0)) u_bus_sva (
  .clk      (clk),
  .rst      (rst),
  .stb      (stb),
  .ack      (ack),
  .dev_stb  ({bus_board.stb, bus_timer.stb}),
  .led_g    (),
  .led_r    (),
  .hex_flat ()
);

bind board_out_regs bio_sva #(.BUS_CHECKS(1'b0), .OUT_CHECKS(1'b1)) u_out_sva (
  .clk      (clk),
  .rst      (rst),
  .stb      (),
  .ack      (),
  .dev_stb  (),
  .led_g    (led_g),
  .led_r    (led_r),
  .hex_flat ({hex_n[7], hex_n[6], hex_n[5], hex_n[4],
              hex_n[3], hex_n[2], hex_n[1], hex_n[0]})
);

`default_nettype wire

// File: testbench/bio_tb.sv
// testbench for the board I/O subsystem: clock, reset, bus tasks,
// compare tasks and directed tests
`timescale 1ns/100ps
`default_nettype none

`include "bio_settings.svh"

module bio_tb;
  import bio_pkg::*;

  logic       clk;
  logic       rst;
  logic       stb;
  logic       we;
  addr_t      addr;
  word_t      wdata;
  word_t      rdata;
  logic       ack;
  led_g_t     led_g;
  led_r_t     led_r;
  seg_t       hex0_n;
  seg_t       hex1_n;
  seg_t       hex2_n;
  seg_t       hex3_n;
  seg_t       hex4_n;
  seg_t       hex5_n;
  seg_t       hex6_n;
  seg_t       hex7_n;
  logic [2:0] key_n;
  sw_t        sw;
  logic       irq;

  int     errors;
  int     checks;
  // expected display state
  seg_t   exp_hex [0:7];
  led_r_t exp_led_r;
  led_g_t exp_led_g;

  bio_top u_bio_top (.*);

  always #2 clk = ~clk;

  // ####################################################################
  // compare tasks
  // ####################################################################
  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_seg(input string name, input seg_t got, input seg_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_led_r(input string name, input led_r_t got, input led_r_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_led_g(input string name, input led_g_t got, input led_g_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  // ####################################################################
  // bus access, one strobe cycle each
  // ####################################################################
  function automatic addr_t make_addr(input logic [1:0] dev, input off_t off);
    return {dev, off};
  endfunction

  task automatic bus_write(input addr_t a, input word_t d);
    @(negedge clk);
    stb   = 1'b1;
    we    = 1'b1;
    addr  = a;
    wdata = d;
    #1;
    check_bit("ack", ack, 1'b1);
    @(negedge clk);
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic bus_read(input addr_t a, output word_t d);
    @(negedge clk);
    stb  = 1'b1;
    we   = 1'b0;
    addr = a;
    #1;
    check_bit("ack", ack, 1'b1);
    d = rdata;
    @(negedge clk);
    stb = 1'b0;
  endtask

  task automatic read_expect(input string name, input addr_t a, input word_t exp);
    word_t d;
    bus_read(a, d);
    check_word(name, d, exp);
  endtask

  function automatic seg_t hex_out(input int i);
    case (i)
      0: return hex0_n;
      1: return hex1_n;
      2: return hex2_n;
      3: return hex3_n;
      4: return hex4_n;
      5: return hex5_n;
      6: return hex6_n;
      default: return hex7_n;
    endcase
  endfunction

  task automatic compare_outputs();
    for (int i = 0; i < 8; i++) begin
      check_seg($sformatf("hex%0d_n", i), hex_out(i), exp_hex[i]);
    end
    check_led_r("led_r", led_r, exp_led_r);
    check_led_g("led_g", led_g, exp_led_g);
  endtask

  task automatic wait_irq(input int limit, output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < limit) begin
      @(negedge clk);
      seen = irq;
      n++;
    end
  endtask

  // ####################################################################
  // directed tests
  // ####################################################################
  task automatic reset_values();
    for (int i = 0; i < 8; i++) begin
      exp_hex[i] = '1;
    end
    exp_led_r = '0;
    exp_led_g = '0;
    compare_outputs();
    check_bit("irq", irq, 1'b0);
  endtask

  task automatic display_writes();
    word_t pat;
    for (int i = 0; i < 8; i++) begin
      pat = $urandom;
      bus_write(make_addr(`BIO_DEV_BOARD, off_t'(i)), pat);
      // digits are stored inverted
      exp_hex[i] = ~seg_t'(pat);
      compare_outputs();
    end
    pat = $urandom;
    bus_write(make_addr(`BIO_DEV_BOARD, `BIO_OFF_LED_R), pat);
    exp_led_r = led_r_t'(pat);
    compare_outputs();
    pat = $urandom;
    bus_write(make_addr(`BIO_DEV_BOARD, `BIO_OFF_LED_G), pat);
    exp_led_g = led_g_t'(pat);
    compare_outputs();
    for (int o = 12; o < 16; o++) begin
      bus_write(make_addr(`BIO_DEV_BOARD, off_t'(o)), $urandom);
      compare_outputs();
    end
  endtask

  task automatic input_word();
    sw_t        sw_val;
    logic [2:0] key_val;
    for (int n = 0; n < 4; n++) begin
      sw_val  = sw_t'($urandom);
      key_val = 3'($urandom);
      sw      = sw_val;
      key_n   = key_val;
      repeat (`BIO_SYNC_STAGES + 1) @(negedge clk);
      // keys on top, switches at the bottom
      read_expect("input rdata", make_addr(`BIO_DEV_BOARD, `BIO_OFF_INPUT),
                  {~key_val, 11'd0, sw_val});
    end
  endtask

  task automatic keypress_latch();
    key_t  exp_kp;
    addr_t kp_addr;
    kp_addr = make_addr(`BIO_DEV_BOARD, `BIO_OFF_KEYPRESS);
    key_n   = 3'b111;
    repeat (`BIO_SYNC_STAGES + 2) @(negedge clk);
    bus_write(kp_addr, word_t'(3'b111));
    exp_kp = '0;
    read_expect("keypress rdata", kp_addr, word_t'(exp_kp));
    for (int k = 0; k < 3; k++) begin
      key_n[k] = 1'b0;
      repeat (`BIO_SYNC_STAGES + 2) @(negedge clk);
      key_n[k] = 1'b1;
      repeat (`BIO_SYNC_STAGES + 2) @(negedge clk);
      exp_kp[k] = 1'b1;
      read_expect("keypress rdata", kp_addr, word_t'(exp_kp));
    end
    for (int k = 0; k < 3; k++) begin
      bus_write(kp_addr, word_t'(1) << k);
      exp_kp[k] = 1'b0;
      read_expect("keypress rdata", kp_addr, word_t'(exp_kp));
    end
  endtask

  task automatic timer_irq();
    word_t div;
    int    limit;
    logic  seen;
    div   = 8 + ($urandom % 8);
    limit = 2 * int'(div) + 10;
    bus_write(make_addr(`BIO_DEV_TIMER, `BIO_OFF_TDIV), div);
    read_expect("divisor rdata", make_addr(`BIO_DEV_TIMER, `BIO_OFF_TDIV), div);
    wait_irq(limit, seen);
    if (!seen) begin
      errors++;
      $display("irq did not rise within %0d cycles of the divisor write", limit);
    end
    read_expect("status rdata", make_addr(`BIO_DEV_TIMER, `BIO_OFF_TSTAT), word_t'(1));
    bus_write(make_addr(`BIO_DEV_TIMER, `BIO_OFF_TSTAT), word_t'(1));
    check_bit("irq", irq, 1'b0);
    // stopped timer never expires
    bus_write(make_addr(`BIO_DEV_TIMER, `BIO_OFF_TDIV), '0);
    bus_write(make_addr(`BIO_DEV_TIMER, `BIO_OFF_TSTAT), word_t'(1));
    for (int n = 0; n < limit; n++) begin
      @(negedge clk);
      check_bit("irq", irq, 1'b0);
    end
  endtask

  task automatic unmapped_reads();
    for (int dev = 2; dev < 4; dev++) begin
      for (int n = 0; n < 4; n++) begin
        read_expect("unmapped rdata", make_addr(2'(dev), off_t'($urandom)), '0);
      end
    end
  endtask

  initial begin
    errors = 0;
    checks = 0;
    clk    = 1'b0;
    rst    = 1'b1;
    stb    = 1'b0;
    we     = 1'b0;
    addr   = '0;
    wdata  = '0;
    key_n  = 3'b111;
    sw     = '0;
    void'($urandom(32'h45817d08));
    repeat (4) @(negedge clk);
    rst = 1'b0;
    reset_values();
    display_writes();
    input_word();
    keypress_latch();
    timer_irq();
    unmapped_reads();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
rtl/bio_pkg.sv
rtl/bio_bus_if.sv
rtl/input_sync.sv
rtl/io_bus_ctrl.sv
rtl/board_out_regs.sv
rtl/board_in_regs.sv
rtl/interval_timer.sv
rtl/bio_top.sv
testbench/bio_sva.sv
testbench/bio_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module bio_tb \
  --Mdir obj_dir -o bio_tb_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/bio_tb_sim)
echo "$out"
echo "$out" | grep -qx "all tests passed" && exit 0 || exit 1
